/* hw/line_buffer.sv */
`timescale 1ns/10ps

module line_buffer import spu_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      line_start,
	input  logic      half,			// half being drawn
	input  sl_pixel_t sl_wr,
	input  xpos_t     sl_waddr,
	input  logic      cbeg,
	input  logic      post_cbeg,
	output color_t    spixel,
	output logic      spx_en
);

	sl_pixel_t line_mem [2][LINE_PIXELS];
	xpos_t     scan_addr;
	xpos_t     sweep_addr;
	logic      sweep_busy;		// clearing both halves after reset
	logic      scan_half;
	sl_pixel_t scan_q;

	assign scan_half = !half;
	assign scan_q    = line_mem[scan_half][scan_addr];

	// --------------------------------------------------
	// reset sweep, 512 clocks
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sweep_busy <= 1'b1;
			sweep_addr <= '0;
		end
		else if (sweep_busy)
		begin
			sweep_addr <= sweep_addr + 9'd1;
			if (sweep_addr == xpos_t'(LINE_PIXELS - 1))
			begin
				sweep_busy <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// scan-out of the other half
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			scan_addr <= '0;
			spixel    <= '0;
			spx_en    <= 1'b0;
		end
		else
		begin
			if (line_start)
			begin
				scan_addr <= '0;
			end
			else if (post_cbeg)
			begin
				scan_addr <= scan_addr + 9'd1;	// after the clear
			end
			if (cbeg)
			begin
				spixel <= scan_q.color;
				spx_en <= scan_q.valid;
			end
		end
	end

	// one write port per half, roles swap with half
	always_ff @(posedge clk)
	begin
		for (int h = 0; h < 2; h++)
		begin
			if (sweep_busy)
			begin
				line_mem[h][sweep_addr] <= '0;
			end
			else if (h == int'(half))
			begin
				if (sl_wr.valid)
				begin
					line_mem[h][sl_waddr] <= sl_wr;	// later sprite overwrites
				end
			end
			else if (post_cbeg)
			begin
				line_mem[h][scan_addr] <= '0;	// clear behind the read
			end
		end
	end

endmodule

/* hw/sprite_engine.sv */
`timescale 1ns/10ps

module sprite_engine import spu_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        line_start,
	input  vline_t      vline,
	input  logic        enable,
	output sprite_idx_t desc_sel,
	output logic [2:0]  desc_ofs,
	input  logic [7:0]  desc_byte,
	output pal_idx_t    pal_idx,
	input  logic [7:0]  pal_entry,
	output logic        mem_req,
	output mem_addr_t   mem_addr,
	input  logic        mem_next,
	input  logic        mem_strobe,
	input  mem_word_t   mem_data,
	output sl_pixel_t   sl_wr,
	output xpos_t       sl_waddr
);

	engine_state_t state;
	logic          step;			// second byte of a two-byte state
	sprite_idx_t   sprite;
	logic [6:0]    words_left;		// words still to draw
	logic [6:0]    recv_left;		// words still to arrive
	logic [2:0]    pix_left;		// pixels left in shreg
	logic          nxt_valid;		// word parked in nxt_word

	// descriptor fields, latched during the walk
	cres_t      cres_q;
	logic [3:0] bank;
	logic       flipx, flipy;
	logic [7:0] y_lo, x_lo;
	logic [4:0] base_hi;
	logic [7:0] base_lo;
	vline_t     row;				// row inside the sprite, flip applied
	logic [6:0] width;
	xpos_t      xcur;
	mem_word_t  shreg, nxt_word;

	vline_t     y_full, x_full, row_raw, row_flip;
	logic [8:0] height4;
	logic [9:0] y_end, span;
	logic       s_act, s_vis;
	logic       take, hold_load;
	mem_word_t  take_word;
	mem_addr_t  row_addr;
	logic [2:0] ppw_m1;
	color_t     pix_color;
	logic       pix_opaque;

	// --------------------------------------------------
	// descriptor read address
	// --------------------------------------------------
	always_comb
	begin
		case (state)
			ST_CTRL:   desc_ofs = step ? OFS_ADDR_H : OFS_CTRL;	// flipy needed before row
			ST_GEOM_Y: desc_ofs = step ? OFS_Y_H : OFS_Y_L;
			ST_GEOM_X: desc_ofs = step ? OFS_X_H : OFS_X_L;
			ST_BASE:   desc_ofs = step ? OFS_ADDR_M : OFS_ADDR_L;
			default:   desc_ofs = OFS_CTRL;
		endcase
	end
	assign desc_sel = sprite;

	// geometry, valid in the step that reads the high byte
	assign s_act    = desc_byte[1:0] != CRES_OFF;
	assign height4  = {desc_byte[7:1], 2'b00};
	assign y_full   = {desc_byte[0], y_lo};
	assign y_end    = {1'b0, y_full} + {1'b0, height4};	// no wrap past 511
	assign s_vis    = (vline >= y_full) && ({1'b0, vline} < y_end);
	assign row_raw  = vline - y_full;
	assign row_flip = height4 - 9'd1 - row_raw;
	assign x_full   = {desc_byte[0], x_lo};

	// pixels per line of the sprite, wraps mod 512 with the address
	always_comb
	begin
		case (cres_q)
			CRES_4C:  span = {desc_byte[7:1], 3'b000};
			CRES_16C: span = {1'b0, desc_byte[7:1], 2'b00};
			default:  span = {3'b000, desc_byte[7:1]};
		endcase
	end
	assign ppw_m1 = (cres_q == CRES_4C) ? 3'd7 : ((cres_q == CRES_16C) ? 3'd3 : 3'd0);

	// first word of the row = base + r * width
	assign row_addr = {base_hi, desc_byte, base_lo} + mem_addr_t'(row) * mem_addr_t'(width);

	// word hand-off, strobe outside fetch parks in nxt_word
	assign take      = (state == ST_FETCH) && (nxt_valid || mem_strobe);
	assign take_word = nxt_valid ? nxt_word : mem_data;
	assign hold_load = mem_strobe && !(take && !nxt_valid);

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state      <= ST_IDLE;
			step       <= 1'b0;
			sprite     <= '0;
			mem_req    <= 1'b0;
			nxt_valid  <= 1'b0;
			words_left <= '0;
			recv_left  <= '0;
			pix_left   <= '0;
		end
		else if (line_start)
		begin
			state     <= (enable && (vline < VIS_LINES)) ? ST_CTRL : ST_IDLE;	// line 0 included
			step      <= 1'b0;
			sprite    <= '0;
			mem_req   <= 1'b0;
			nxt_valid <= 1'b0;
		end
		else
		begin
			nxt_valid <= (nxt_valid && !take) || hold_load;
			if (mem_strobe)
			begin
				recv_left <= recv_left - 7'd1;
				if (recv_left == 7'd1)
				begin
					mem_req <= 1'b0;	// last word in
				end
			end
			case (state)
				ST_CTRL:
				begin
					step <= !step && s_act;
					if (step)
					begin
						state <= ST_GEOM_Y;
					end
					else if (!s_act)
					begin
						state <= ST_NEXT;	// sprite off
					end
				end
				ST_GEOM_Y:
				begin
					step <= !step;
					if (step)
					begin
						state <= s_vis ? ST_GEOM_X : ST_NEXT;
					end
				end
				ST_GEOM_X:
				begin
					step <= !step;
					if (step)
					begin
						state <= (desc_byte[7:1] == 7'd0) ? ST_NEXT : ST_BASE;	// no words
					end
				end
				ST_BASE:
				begin
					step <= !step;
					if (step)
					begin
						mem_req    <= 1'b1;
						words_left <= width;
						recv_left  <= width;
						state      <= ST_FETCH;
					end
				end
				ST_FETCH:
				begin
					if (take)
					begin
						pix_left <= ppw_m1;
						state    <= ST_PIXELS;
					end
				end
				ST_PIXELS:
				begin
					if (pix_left != 3'd0)
					begin
						pix_left <= pix_left - 3'd1;
					end
					else if (words_left == 7'd1)
					begin
						state <= ST_NEXT;
					end
					else
					begin
						words_left <= words_left - 7'd1;
						state      <= ST_FETCH;
					end
				end
				ST_NEXT:
				begin
					if (sprite == sprite_idx_t'(SPRITE_COUNT - 1))
					begin
						state <= ST_IDLE;	// all descriptors walked
					end
					else
					begin
						sprite <= sprite + 5'd1;
						state  <= ST_CTRL;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mem_next)
		begin
			mem_addr <= mem_addr + 21'd1;
		end
		if (hold_load)
		begin
			nxt_word <= mem_data;
		end
		case (state)
			ST_CTRL:
			begin
				if (!step)
				begin
					cres_q <= desc_byte[1:0];
					bank   <= desc_byte[7:4];	// priority bits ignored
				end
				else
				begin
					base_hi <= desc_byte[4:0];
					flipx   <= desc_byte[5];
					flipy   <= desc_byte[6];
				end
			end
			ST_GEOM_Y:
			begin
				if (!step)
				begin
					y_lo <= desc_byte;
				end
				else
				begin
					row <= flipy ? row_flip : row_raw;
				end
			end
			ST_GEOM_X:
			begin
				if (!step)
				begin
					x_lo <= desc_byte;
				end
				else
				begin
					width <= desc_byte[7:1];
					xcur  <= flipx ? (x_full + span[8:0] - 9'd1) : x_full;	// right edge on flip
				end
			end
			ST_BASE:
			begin
				if (!step)
				begin
					base_lo <= desc_byte;
				end
				else
				begin
					mem_addr <= row_addr;
				end
			end
			ST_FETCH:
			begin
				if (take)
				begin
					shreg <= take_word;
				end
			end
			ST_PIXELS:
			begin
				xcur  <= flipx ? (xcur - 9'd1) : (xcur + 9'd1);
				shreg <= (cres_q == CRES_4C) ? (shreg << 2) : (shreg << 4);	// next code to top
			end
			default: ;
		endcase
	end

	// decode of the top pixel in shreg
	always_comb
	begin
		pal_idx = (cres_q == CRES_4C) ? {bank, 2'b00, shreg[15:14]} : {bank, shreg[15:12]};
		if (cres_q == CRES_TC)
		begin
			pix_color  = shreg[13:8];
			pix_opaque = !shreg[14];
		end
		else
		begin
			pix_color  = pal_entry[5:0];
			pix_opaque = !pal_entry[PAL_TRANSP_BIT];
		end
		sl_wr.valid = (state == ST_PIXELS) && pix_opaque;	// valid doubles as write enable
		sl_wr.color = pix_color;
	end
	assign sl_waddr = xcur;

	a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req && !mem_next |=> !mem_req || $stable(mem_addr));

	// an idle engine has no fetch left open
	a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		(state == ST_IDLE) |-> !mem_req && !nxt_valid);

	// only one word may be parked while the previous one is drawn
	a_hold_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
		mem_strobe && nxt_valid |-> state == ST_FETCH);

endmodule

/* hw/sprite_regs.sv */
`timescale 1ns/10ps

module sprite_regs import spu_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  cfg_wr_t     cfg,
	input  sprite_idx_t desc_sel,
	input  logic [2:0]  desc_ofs,
	output logic [7:0]  desc_byte,
	input  pal_idx_t    pal_idx,
	output logic [7:0]  pal_entry,
	output logic        enable
);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	logic [7:0] desc_mem [SPRITE_COUNT*DESC_BYTES];	// {sprite, offset} addressed
	logic [7:0] pal_mem  [2**$bits(pal_idx_t)];		// {bank, code} addressed

	logic desc_we;
	logic pal_we;
	logic en_we;

	// lower half of the cfg space is descriptors, upper half palette
	assign desc_we = cfg.we && !cfg.addr[CFG_PAL_BIT];
	assign pal_we  = cfg.we && cfg.addr[CFG_PAL_BIT];
	assign en_we   = cfg.we && (cfg.addr == CFG_ENABLE_ADDR);	// shares palette 255

	always_ff @(posedge clk)
	begin
		if (desc_we)
		begin
			desc_mem[cfg.addr[7:0]] <= cfg.data;
		end
		if (pal_we)
		begin
			pal_mem[cfg.addr[7:0]] <= cfg.data;
		end
	end

	// master enable, bit 0 of the last cfg byte
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			enable <= 1'b0;
		end
		else if (en_we)
		begin
			enable <= cfg.data[0];
		end
	end

	// --------------------------------------------------
	// engine read ports, combinational
	// --------------------------------------------------
	assign desc_byte = desc_mem[{desc_sel, desc_ofs}];	// byte of the walked sprite
	assign pal_entry = pal_mem[pal_idx];				// colour + transparent flag

	// a write with a floating address would corrupt an unknown entry
	a_cfg_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
		cfg.we |-> !$isunknown(cfg.addr));

endmodule

/* hw/sprite_top.sv */
`timescale 1ns/10ps

module sprite_top import spu_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  cfg_wr_t   cfg,
	input  logic      line_start,
	input  logic      pre_vline,
	input  logic      cbeg,
	input  logic      post_cbeg,
	output logic      mem_req,
	output mem_addr_t mem_addr,
	input  logic      mem_next,
	input  logic      mem_strobe,
	input  mem_word_t mem_data,
	output color_t    spixel,
	output logic      spx_en
);

	vline_t      vline_q;		// line counter
	vline_t      vline_next;
	vline_t      vline;			// current line, next value during line_start
	sprite_idx_t desc_sel;
	logic [2:0]  desc_ofs;
	logic [7:0]  desc_byte;
	pal_idx_t    pal_idx;
	logic [7:0]  pal_entry;
	logic        enable;
	sl_pixel_t   sl_wr;
	xpos_t       sl_waddr;

	// --------------------------------------------------
	// line counter
	// --------------------------------------------------
	assign vline_next = pre_vline ? '0 : (vline_q + 9'd1);
	assign vline      = line_start ? vline_next : vline_q;	// engine decides on the new line

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vline_q <= '0;
		end
		else if (line_start)
		begin
			vline_q <= vline_next;
		end
	end

	sprite_regs sprite_regs_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg       (cfg),
		.desc_sel  (desc_sel),
		.desc_ofs  (desc_ofs),
		.desc_byte (desc_byte),
		.pal_idx   (pal_idx),
		.pal_entry (pal_entry),
		.enable    (enable)
	);

	sprite_engine sprite_engine_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.vline      (vline),
		.enable     (enable),
		.desc_sel   (desc_sel),
		.desc_ofs   (desc_ofs),
		.desc_byte  (desc_byte),
		.pal_idx    (pal_idx),
		.pal_entry  (pal_entry),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_next   (mem_next),
		.mem_strobe (mem_strobe),
		.mem_data   (mem_data),
		.sl_wr      (sl_wr),
		.sl_waddr   (sl_waddr)
	);

	// line v drawn into half v[0]
	line_buffer line_buffer_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.half       (vline_q[0]),
		.sl_wr      (sl_wr),
		.sl_waddr   (sl_waddr),
		.cbeg       (cbeg),
		.post_cbeg  (post_cbeg),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

endmodule

/* hw/spu_pkg.sv */
package spu_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int SPRITE_COUNT = 32;	// descriptors in the file
	localparam int DESC_BYTES   = 8;	// bytes per descriptor
	localparam int LINE_PIXELS  = 512;	// one line buffer half
	localparam int VIS_LINES    = 288;	// visible raster lines

	// cfg address bit 8 selects palette over descriptors
	localparam int CFG_PAL_BIT = 8;
	localparam logic [8:0] CFG_ENABLE_ADDR = 9'h1ff;	// also palette 255

	// palette entry layout
	localparam int PAL_TRANSP_BIT = 6;	// set = pixel not drawn

	// --------------------------------------------------
	// plain types
	// --------------------------------------------------
	typedef logic [8:0]  vline_t;		// raster line number
	typedef logic [8:0]  xpos_t;		// line buffer address
	typedef logic [4:0]  sprite_idx_t;
	typedef logic [20:0] mem_addr_t;	// word address
	typedef logic [15:0] mem_word_t;
	typedef logic [5:0]  color_t;
	typedef logic [7:0]  pal_idx_t;		// {bank, code}
	typedef logic [8:0]  cfg_addr_t;
	typedef logic [1:0]  cres_t;

	// colour modes, 0 switches the sprite off
	localparam cres_t CRES_OFF = 2'd0;
	localparam cres_t CRES_4C  = 2'd1;
	localparam cres_t CRES_16C = 2'd2;
	localparam cres_t CRES_TC  = 2'd3;

	// --------------------------------------------------
	// descriptor byte offsets
	// --------------------------------------------------
	localparam logic [2:0] OFS_X_L    = 3'd0;	// x[7:0]
	localparam logic [2:0] OFS_X_H    = 3'd1;	// x[8], width in words
	localparam logic [2:0] OFS_Y_L    = 3'd2;	// y[7:0]
	localparam logic [2:0] OFS_Y_H    = 3'd3;	// y[8], height / 4
	localparam logic [2:0] OFS_CTRL   = 3'd4;	// cres, pri, bank
	localparam logic [2:0] OFS_ADDR_L = 3'd5;	// base[7:0]
	localparam logic [2:0] OFS_ADDR_M = 3'd6;	// base[15:8]
	localparam logic [2:0] OFS_ADDR_H = 3'd7;	// base[20:16], flipx, flipy

	// engine walk, one descriptor byte per cycle
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CTRL,
		ST_GEOM_Y,
		ST_GEOM_X,
		ST_BASE,
		ST_FETCH,
		ST_PIXELS,
		ST_NEXT
	} engine_state_t;

	typedef struct packed {
		logic   valid;		// opaque pixel present
		color_t color;
	} sl_pixel_t;

	typedef struct packed {
		logic       we;
		cfg_addr_t  addr;
		logic [7:0] data;
	} cfg_wr_t;

endpackage

/* project.f */
+incdir+verif
hw/spu_pkg.sv
hw/sprite_regs.sv
hw/sprite_engine.sv
hw/line_buffer.sv
hw/sprite_top.sv
verif/sprite_tb.sv

/* run.sh */
#!/bin/sh
# build the sprite testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module sprite_tb -f project.f \
	&& ./obj_dir/Vsprite_tb | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/sprite_model.svh */
// --------------------------------------------------
// random source and memory contents
// --------------------------------------------------
logic [31:0] lfsr_state = 32'he88e_505b;
logic [31:0] mem_salt = '0;	// changes the memory image per test

// x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
	logic [31:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

// hashed word, every address bit counts
function automatic mem_word_t mem_word(input mem_addr_t a);
	logic [31:0] h;
	h = ({11'd0, a} ^ mem_salt) * 32'h9e37_79b1;
	h = h ^ (h >> 15);
	return h[31:16];
endfunction

// --------------------------------------------------
// configuration copy
// --------------------------------------------------
logic [7:0] desc_copy [SPRITE_COUNT*DESC_BYTES];
logic [7:0] pal_copy [256];
logic       en_copy;

function automatic void set_sprite(input int s, input int x, input int y, input int h,
		input int w, input cres_t cres, input logic [3:0] bank, input logic [1:0] pri,
		input mem_addr_t base, input logic fx, input logic fy);
	xpos_t  xv;
	vline_t yv;
	xv = xpos_t'(x);
	yv = vline_t'(y);
	desc_copy[s*8 + 0] = xv[7:0];
	desc_copy[s*8 + 1] = {7'(w), xv[8]};	// width in words
	desc_copy[s*8 + 2] = yv[7:0];
	desc_copy[s*8 + 3] = {7'(h), yv[8]};	// height in 4-line units
	desc_copy[s*8 + 4] = {bank, pri, cres};
	desc_copy[s*8 + 5] = base[7:0];
	desc_copy[s*8 + 6] = base[15:8];
	desc_copy[s*8 + 7] = {1'b0, fy, fx, base[20:16]};
endfunction

function automatic void clear_sprites();
	for (int i = 0; i < SPRITE_COUNT * DESC_BYTES; i++)
	begin
		desc_copy[i] = 8'h00;	// cres 0, sprite off
	end
endfunction

// about one entry in four transparent when asked for
function automatic void fill_palette(input logic with_transp);
	logic [5:0] col;
	logic       tr;
	for (int i = 0; i < 256; i++)
	begin
		col = 6'(lfsr_bits(6));
		tr  = with_transp && (lfsr_bits(2) == 0);
		pal_copy[i] = {1'b0, tr, col};
	end
endfunction

function automatic void random_sprite(input int s);
	int x;
	int y;
	int h;
	int w;
	x = 40 + int'(lfsr_bits(8));
	y = int'(lfsr_bits(4));
	h = 1 + int'(lfsr_bits(2));
	w = 1 + int'(lfsr_bits(1));	// short rows keep 32 sprites inside one line
	set_sprite(s, x, y, h, w, cres_t'(lfsr_bits(2)), 4'(lfsr_bits(4)), 2'(lfsr_bits(2)),
		mem_addr_t'(lfsr_bits(21)), 1'(lfsr_bits(1)), 1'(lfsr_bits(1)));
endfunction

// --------------------------------------------------
// reference renderer
// --------------------------------------------------
logic      draw_valid [LINE_PIXELS];
color_t    draw_color [LINE_PIXELS];
mem_addr_t exp_addr [$];	// reads of the line, in order

function automatic void render_line(input int v);
	int         x, y, h, w, r, ppw, cnt, n;
	cres_t      cres;
	logic [3:0] bank;
	logic       fx, fy, opaque;
	mem_addr_t  base, a;
	mem_word_t  word;
	pal_idx_t   idx;
	logic [7:0] ent;
	color_t     col;
	xpos_t      pos;
	for (int i = 0; i < LINE_PIXELS; i++)
	begin
		draw_valid[i] = 1'b0;
		draw_color[i] = '0;
	end
	exp_addr.delete();
	if (!en_copy)
	begin
		return;
	end
	for (int s = 0; s < SPRITE_COUNT; s++)
	begin
		x    = int'({desc_copy[s*8 + 1][0], desc_copy[s*8 + 0]});
		w    = int'(desc_copy[s*8 + 1][7:1]);
		y    = int'({desc_copy[s*8 + 3][0], desc_copy[s*8 + 2]});
		h    = int'(desc_copy[s*8 + 3][7:1]);
		cres = desc_copy[s*8 + 4][1:0];
		bank = desc_copy[s*8 + 4][7:4];
		base = {desc_copy[s*8 + 7][4:0], desc_copy[s*8 + 6], desc_copy[s*8 + 5]};
		fx   = desc_copy[s*8 + 7][5];
		fy   = desc_copy[s*8 + 7][6];
		if (cres == CRES_OFF || v < y || v >= y + 4 * h || w == 0)
		begin
			continue;
		end
		r   = fy ? (4 * h - 1 - (v - y)) : (v - y);
		ppw = (cres == CRES_4C) ? 8 : ((cres == CRES_16C) ? 4 : 1);
		cnt = w * ppw;
		for (int k = 0; k < w; k++)
		begin
			a = base + mem_addr_t'(r * w + k);
			exp_addr.push_back(a);
			word = mem_word(a);
			for (int p = 0; p < ppw; p++)
			begin
				if (cres == CRES_TC)
				begin
					col    = word[13:8];
					opaque = !word[14];
				end
				else
				begin
					if (cres == CRES_4C)
						idx = {bank, 2'b00, word[15 - 2*p -: 2]};
					else
						idx = {bank, word[15 - 4*p -: 4]};
					ent    = pal_copy[idx];
					col    = ent[5:0];
					opaque = !ent[6];
				end
				n   = k * ppw + p;
				pos = fx ? xpos_t'(x + cnt - 1 - n) : xpos_t'(x + n);	// mod 512
				if (opaque)
				begin
					draw_valid[pos] = 1'b1;	// later sprite overwrites
					draw_color[pos] = col;
				end
			end
		end
	end
endfunction

/* verif/sprite_tb.sv */
`timescale 1ns/10ps

module sprite_tb import spu_pkg::*;
();

	localparam int LINE_CYCLES   = 2048;
	localparam int FIRST_CBEG    = 8;	// cycle of pixel 0 in the line
	localparam int SCAN_PIXELS   = 360;
	localparam int ACCESS_CYCLES = 7;	// memory latency after mem_next
	localparam int TOTAL_LINES   = 84;

	logic      clk;
	logic      arst_n;
	cfg_wr_t   cfg;
	logic      line_start, pre_vline, cbeg, post_cbeg;
	logic      mem_req;
	mem_addr_t mem_addr;
	logic      mem_next, mem_strobe;
	mem_word_t mem_data;
	color_t    spixel;
	logic      spx_en;

	mem_addr_t got_addr [$];	// addresses accepted by the responder
	logic      scan_valid [LINE_PIXELS];
	color_t    scan_color [LINE_PIXELS];
	int        errors = 0;
	int        checks = 0;
	int        tests_run = 0;
	int        tests_failed = 0;
	int        err_mark, chk_mark;
	string     test_name;

	`include "sprite_model.svh"

	sprite_top sprite_top_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg        (cfg),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.cbeg       (cbeg),
		.post_cbeg  (post_cbeg),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_next   (mem_next),
		.mem_strobe (mem_strobe),
		.mem_data   (mem_data),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// memory responder, one word in flight
	// --------------------------------------------------
	initial
	begin : responder
		mem_addr_t a;
		mem_next   = 1'b0;
		mem_strobe = 1'b0;
		mem_data   = '0;
		forever
		begin
			@(posedge clk);
			if (mem_req)
			begin
				repeat (1 + lfsr_bits(3) % 6) @(posedge clk);	// random accept delay
				a = mem_addr;
				got_addr.push_back(a);
				mem_next <= 1'b1;
				@(posedge clk);
				mem_next <= 1'b0;
				repeat (ACCESS_CYCLES - 1) @(posedge clk);
				mem_strobe <= 1'b1;
				mem_data   <= mem_word(a);
				@(posedge clk);
				mem_strobe <= 1'b0;	// then one idle cycle so mem_req can drop
			end
		end
	end

	initial
	begin : watchdog
		repeat ((TOTAL_LINES + 4) * LINE_CYCLES) @(posedge clk);
		$display("timeout: the run did not end within %0d lines", TOTAL_LINES + 4);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic compare_pixel(input int line, input int x, input logic exp_v,
			input color_t exp_c, input logic got_v, input color_t got_c);
		checks++;
		if (got_v !== exp_v || (exp_v && got_c !== exp_c))
		begin
			errors++;
			$display("[ERROR] %0t: line %0d x %0d expected en %0b colour %02h, got en %0b colour %02h",
				$time, line, x, exp_v, exp_c, got_v, got_c);
		end
	endtask

	task automatic compare_addr(input int line, input int idx, input mem_addr_t exp_a,
			input mem_addr_t got_a);
		checks++;
		if (got_a !== exp_a)
		begin
			errors++;
			$display("[ERROR] %0t: line %0d read %0d expected address %06h, got %06h",
				$time, line, idx, exp_a, got_a);
		end
	endtask

	task automatic begin_test(input string name);
		tests_run++;
		test_name = name;
		err_mark  = errors;
		chk_mark  = checks;
	endtask

	task automatic finish_test();
		if (errors != err_mark)
		begin
			tests_failed++;
		end
		$display("test %0d %s: %s, %0d checks, %0d errors", tests_run, test_name,
			(errors == err_mark) ? "ok" : "FAILED", checks - chk_mark, errors - err_mark);
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic write_cfg(input int a, input logic [7:0] d);
		@(posedge clk);
		cfg <= '{we: 1'b1, addr: cfg_addr_t'(a), data: d};
	endtask

	// palette 255 goes last, its bit 0 is the enable
	task automatic load_config();
		pal_copy[255][0] = en_copy;
		for (int i = 0; i < 256; i++)
			write_cfg(i, desc_copy[i]);
		for (int i = 0; i < 256; i++)
			write_cfg(256 + i, pal_copy[i]);
		@(posedge clk);
		cfg <= '0;
	endtask

	function automatic logic is_cbeg(input int c);
		return c >= FIRST_CBEG && c < FIRST_CBEG + 4 * SCAN_PIXELS && (c - FIRST_CBEG) % 4 == 0;
	endfunction

	// draws line v, scans line v - 1 unless it opens a frame
	task automatic run_line(input int v, input logic first);
		int i;
		for (int p = 0; p < LINE_PIXELS; p++)
		begin
			scan_valid[p] = draw_valid[p];
			scan_color[p] = draw_color[p];
		end
		render_line(v);
		got_addr.delete();
		for (int c = 0; c < LINE_CYCLES; c++)
		begin
			@(posedge clk);
			i = c - FIRST_CBEG - 2;	// pixel registered one clock after cbeg
			if (!first && i >= 0 && i < 4 * SCAN_PIXELS && i % 4 == 0)
			begin
				compare_pixel(v - 1, i / 4, scan_valid[i / 4], scan_color[i / 4], spx_en, spixel);
			end
			line_start <= (c == 0);
			pre_vline  <= (c == 0) && first;
			cbeg       <= is_cbeg(c);
			post_cbeg  <= is_cbeg(c - 1);
		end
		if (got_addr.size() != exp_addr.size())
		begin
			errors++;
			$display("line %0d: the engine read %0d memory words where %0d were expected",
				v, got_addr.size(), exp_addr.size());
		end
		else
		begin
			for (int k = 0; k < exp_addr.size(); k++)
				compare_addr(v, k, exp_addr[k], got_addr[k]);
		end
	endtask

	// odd last line keeps half 0 clean for the next frame
	task automatic run_frame(input int last);
		for (int v = 0; v <= last; v++)
			run_line(v, v == 0);
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin : main
		arst_n     = 1'b0;
		cfg        = '0;
		line_start = 1'b0;
		pre_vline  = 1'b0;
		cbeg       = 1'b0;
		post_cbeg  = 1'b0;
		for (int p = 0; p < LINE_PIXELS; p++)
		begin
			draw_valid[p] = 1'b0;
			draw_color[p] = '0;
		end
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		begin_test("enable clear");
		mem_salt = lfsr_bits(32);
		clear_sprites();
		fill_palette(1'b0);
		set_sprite(0, 20, 0, 2, 4, CRES_4C, 4'd1, 2'd0, 21'h000100, 1'b0, 1'b0);
		en_copy = 1'b0;
		load_config();
		run_frame(3);
		finish_test();

		begin_test("single 4-colour sprite");
		mem_salt = lfsr_bits(32);
		clear_sprites();
		fill_palette(1'b0);	// all entries opaque
		set_sprite(0, 40, 2, 2, 3, CRES_4C, 4'd5, 2'd0, 21'h012345, 1'b0, 1'b0);
		en_copy = 1'b1;
		load_config();
		run_frame(11);
		finish_test();

		begin_test("16-colour and true colour with flips");
		mem_salt = lfsr_bits(32);
		clear_sprites();
		fill_palette(1'b1);
		set_sprite(0, 100, 1, 2, 5, CRES_16C, 4'd3, 2'd1, 21'h1ffff0, 1'b1, 1'b1);	// wraps memory
		set_sprite(1, 110, 3, 2, 12, CRES_TC, 4'd0, 2'd2, 21'h004000, 1'b1, 1'b1);
		set_sprite(2, 90, 0, 1, 2, CRES_16C, 4'd9, 2'd0, 21'h0a0000, 1'b0, 1'b1);
		en_copy = 1'b1;
		load_config();
		run_frame(13);
		finish_test();

		begin_test("random overlapping sprites");
		mem_salt = lfsr_bits(32);
		fill_palette(1'b1);
		for (int s = 0; s < SPRITE_COUNT; s++)
			random_sprite(s);
		en_copy = 1'b1;
		load_config();
		run_frame(21);
		finish_test();

		begin_test("buffer wrap and clear");
		mem_salt = lfsr_bits(32);
		clear_sprites();
		fill_palette(1'b1);
		set_sprite(0, 500, 4, 1, 3, CRES_4C, 4'd2, 2'd0, 21'h030000, 1'b0, 1'b0);	// 500..11
		set_sprite(1, 200, 9, 1, 4, CRES_16C, 4'd7, 2'd3, 21'h055555, 1'b1, 1'b0);
		en_copy = 1'b1;
		load_config();
		run_frame(15);
		run_frame(15);	// same lines again, nothing left over
		finish_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			checks, errors);
		if (errors == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
